// ==== logic/immu_pkg.sv ====
package immu_pkg;

    // ****************************************
    // address and page geometry
    // ****************************************
    localparam int VADDR_W     = 64;
    localparam int VA_SIG_W    = 39;
    localparam int PAGE_OFS_W  = 12;
    localparam int VPN_W       = 27;
    localparam int PPN_W       = 44;
    localparam int ASID_W      = 16;
    localparam int PTE_W       = 128;

    // ****************************************
    // tlb sizing
    // ****************************************
    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;

    // same layout as the word returned by the l2 tlb
    typedef struct packed {
        logic [ASID_W-1:0] asid;
        logic [PPN_W-1:0]  ppn;
        logic [3:0]        pad_hi;
        logic              g;
        logic              u;
        logic              x;
        logic [2:0]        pad_mid;
        logic [VPN_W-1:0]  vpn;
        logic [27:0]       pad_lo;
        // page level, always a 4K leaf here
        logic [2:0]        level;
    } tlb_entry_t;

    // miss handling
    typedef enum logic [1:0] {
        IDLE       = 2'h0,
        SUBMIT_REQ = 2'h1,
        WAIT_RESP  = 2'h3,
        SEND_ADDR  = 2'h2
    } walk_state_t;

    // privilege levels, hypervisor encoding unused
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

endpackage

// ==== logic/tlb_lookup_if.sv ====
interface tlb_lookup_if import immu_pkg::*; ();

    // request side, from the translate stage
    logic [VPN_W-1:0]  vpn;
    logic [ASID_W-1:0] asid;
    logic              lookup_valid;

    // result side, from the tlb
    logic              hit;
    tlb_entry_t        hit_entry;

    modport array (
        input  vpn,
        input  asid,
        input  lookup_valid,
        output hit,
        output hit_entry
    );

    modport stage (
        output vpn,
        output asid,
        output lookup_valid,
        input  hit,
        input  hit_entry
    );

endinterface

// ==== logic/walk_if.sv ====
interface walk_if import immu_pkg::*; ();

    // stage side
    logic       miss_start;
    logic       walk_release;

    // requester side
    logic       walk_done;
    tlb_entry_t walk_entry;
    logic       walk_error;

    modport requester (
        input  miss_start,
        input  walk_release,
        output walk_done,
        output walk_entry,
        output walk_error
    );

    modport stage (
        output miss_start,
        output walk_release,
        input  walk_done,
        input  walk_entry,
        input  walk_error
    );

endinterface

// ==== logic/page_walk_requester.sv ====
module page_walk_requester import immu_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush_flag,
    input  logic             immu_miss_ready,
    input  logic             pte_valid,
    input  logic [PTE_W-1:0] pte,
    input  logic             pte_error,
    output logic             immu_miss_valid,
    output logic             refill_en,
    output tlb_entry_t       refill_entry,
    walk_if.requester        walk
);

    walk_state_t state;
    walk_state_t state_nxt;
    logic        pte_accept;
    tlb_entry_t  pte_reg;
    logic        pte_error_reg;

    // ****************************************
    // miss fsm
    // ****************************************
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (walk.miss_start) begin
                    state_nxt = SUBMIT_REQ;
                end
            end
            SUBMIT_REQ: begin
                if (immu_miss_ready) begin
                    state_nxt = WAIT_RESP;
                end
            end
            WAIT_RESP: begin
                if (pte_valid) begin
                    state_nxt = SEND_ADDR;
                end
            end
            SEND_ADDR: begin
                // held until the pending fetch reaches the output register
                if (walk.walk_release) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (flush_flag) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ready to the l2 tlb is tied high, so valid alone accepts
    assign pte_accept = (state == WAIT_RESP) & pte_valid;

    always_ff @(posedge clk) begin
        if (pte_accept) begin
            pte_reg       <= tlb_entry_t'(pte);
            pte_error_reg <= pte_error;
        end
    end

    assign immu_miss_valid = (state == SUBMIT_REQ);

    // refill straight from the bus, same cycle as acceptance
    assign refill_en    = pte_accept;
    assign refill_entry = tlb_entry_t'(pte);

    assign walk.walk_done  = (state == SEND_ADDR);
    assign walk.walk_entry = pte_reg;
    assign walk.walk_error = pte_error_reg;

endmodule

// ==== logic/itlb_array.sv ====
module itlb_array import immu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sflush_vma_valid,
    input  logic       refill_en,
    input  tlb_entry_t refill_entry,
    tlb_lookup_if.array lookup
);

    tlb_entry_t             entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] entry_valid;
    logic [TLB_ENTRIES-1:0] hit_vec;
    logic [TLB_IDX_W-1:0]   hit_idx;
    logic [TLB_IDX_W-1:0]   free_idx;
    logic                   any_free;
    logic [TLB_IDX_W-1:0]   refill_idx;
    logic [TLB_ENTRIES-2:0] plru;
    logic [TLB_ENTRIES-2:0] plru_nxt;

    // walk the tree following the lru pointers
    function automatic logic [TLB_IDX_W-1:0] plru_victim(input logic [TLB_ENTRIES-2:0] tree);
        int unsigned          node;
        logic [TLB_IDX_W-1:0] idx;
        node = 0;
        idx  = '0;
        for (int lvl = 0; lvl < TLB_IDX_W; lvl++) begin
            idx[TLB_IDX_W-1-lvl] = tree[node];
            node = 2 * node + 1 + tree[node];
        end
        return idx;
    endfunction

    // point every node on the path away from the used slot
    function automatic logic [TLB_ENTRIES-2:0] plru_touch(input logic [TLB_ENTRIES-2:0] tree,
                                                          input logic [TLB_IDX_W-1:0]   idx);
        int unsigned            node;
        logic [TLB_ENTRIES-2:0] upd;
        node = 0;
        upd  = tree;
        for (int lvl = 0; lvl < TLB_IDX_W; lvl++) begin
            upd[node] = ~idx[TLB_IDX_W-1-lvl];
            node = 2 * node + 1 + idx[TLB_IDX_W-1-lvl];
        end
        return upd;
    endfunction

    // ****************************************
    // parallel compare
    // ****************************************
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit_vec[i] = entry_valid[i]
                       & (entries[i].vpn == lookup.vpn)
                       & ((entries[i].asid == lookup.asid) | entries[i].g);
        end
    end

    // or-mux, zero when nothing matches
    always_comb begin
        lookup.hit_entry = '0;
        hit_idx          = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (hit_vec[i]) begin
                lookup.hit_entry = lookup.hit_entry | entries[i];
                hit_idx          = hit_idx | i[TLB_IDX_W-1:0];
            end
        end
    end

    assign lookup.hit = |hit_vec;

    // ****************************************
    // victim selection
    // ****************************************
    always_comb begin
        free_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_idx = i[TLB_IDX_W-1:0];
            end
        end
    end

    assign any_free   = ~&entry_valid;
    assign refill_idx = any_free ? free_idx : plru_victim(plru);

    always_comb begin
        plru_nxt = plru;
        if (lookup.lookup_valid & lookup.hit) begin
            plru_nxt = plru_touch(plru_nxt, hit_idx);
        end
        if (refill_en) begin
            plru_nxt = plru_touch(plru_nxt, refill_idx);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            plru <= '0;
        end else begin
            plru <= plru_nxt;
        end
    end

    // ****************************************
    // storage
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (sflush_vma_valid) begin
            entry_valid <= '0;
        end else if (refill_en) begin
            entry_valid[refill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_en) begin
            entries[refill_idx] <= refill_entry;
        end
    end

endmodule

// ==== logic/translate_stage.sv ====
module translate_stage import immu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [1:0]         current_priv_status,
    input  logic [3:0]         satp_mode,
    input  logic               flush_flag,
    input  logic               mmu_fifo_valid,
    input  logic [VADDR_W-1:0] vaddr,
    input  logic               paddr_ready,
    input  logic [ASID_W-1:0]  satp_asid,
    output logic               mmu_fifo_ready,
    output logic               paddr_valid,
    output logic [VADDR_W-1:0] paddr,
    output logic               paddr_error,
    tlb_lookup_if.stage        lookup,
    walk_if.stage              walk
);

    logic               bypass;
    logic               canonical;
    logic               out_may_load;
    tlb_entry_t         sel_entry;
    logic [VADDR_W-1:0] paddr_nxt;
    logic               error_nxt;

    // machine mode or bare satp skip translation
    assign bypass    = (current_priv_status == PRIV_M) | (satp_mode == 4'h0);
    assign canonical = vaddr[VADDR_W-1:VA_SIG_W] == {(VADDR_W - VA_SIG_W){vaddr[VA_SIG_W-1]}};

    assign lookup.vpn          = vaddr[VA_SIG_W-1:PAGE_OFS_W];
    assign lookup.asid         = satp_asid;
    assign lookup.lookup_valid = mmu_fifo_valid & ~bypass;

    assign walk.miss_start = mmu_fifo_valid & ~bypass & canonical & ~lookup.hit;

    // ****************************************
    // address and error forming
    // ****************************************
    assign sel_entry = walk.walk_done ? walk.walk_entry : lookup.hit_entry;

    assign paddr_nxt = bypass ? vaddr
                              : {{(VADDR_W - PPN_W - PAGE_OFS_W){1'b0}}, sel_entry.ppn,
                                 vaddr[PAGE_OFS_W-1:0]};

    // no execute, wrong user bit for priv, walk error, bad address
    assign error_nxt = ~bypass & (~canonical
                                  | ~sel_entry.x
                                  | (current_priv_status[0] == sel_entry.u)
                                  | (walk.walk_done & walk.walk_error));

    // ****************************************
    // output register
    // ****************************************
    assign out_may_load   = paddr_ready | ~paddr_valid;
    assign mmu_fifo_ready = mmu_fifo_valid & out_may_load
                          & (bypass | ~canonical | lookup.hit | walk.walk_done);

    assign walk.walk_release = mmu_fifo_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            paddr_valid <= 1'b0;
        end else if (flush_flag) begin
            paddr_valid <= 1'b0;
        end else if (out_may_load) begin
            paddr_valid <= mmu_fifo_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (mmu_fifo_ready) begin
            paddr       <= paddr_nxt;
            paddr_error <= error_nxt;
        end
    end

endmodule

// ==== logic/immu_top.sv ====
module immu_top import immu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    // privilege and satp
    input  logic [1:0]         current_priv_status,
    input  logic [3:0]         satp_mode,
    input  logic [ASID_W-1:0]  satp_asid,
    input  logic               flush_flag,
    input  logic               sflush_vma_valid,
    // l2 tlb
    output logic               immu_miss_valid,
    input  logic               immu_miss_ready,
    output logic [VADDR_W-1:0] vaddr_i,
    input  logic               pte_valid,
    output logic               pte_ready_i,
    input  logic [PTE_W-1:0]   pte,
    input  logic               pte_error,
    // fetch fifo
    input  logic               mmu_fifo_valid,
    output logic               mmu_fifo_ready,
    input  logic [VADDR_W-1:0] vaddr,
    // icache
    output logic               paddr_valid,
    input  logic               paddr_ready,
    output logic [VADDR_W-1:0] paddr,
    output logic               paddr_error
);

    tlb_lookup_if lookup_bus ();
    walk_if       walk_bus ();

    logic       refill_en;
    tlb_entry_t refill_entry;

    // l2 tlb always takes the response
    assign pte_ready_i = 1'b1;
    assign vaddr_i     = vaddr;

    page_walk_requester u_walk (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_flag      (flush_flag),
        .immu_miss_ready (immu_miss_ready),
        .pte_valid       (pte_valid),
        .pte             (pte),
        .pte_error       (pte_error),
        .immu_miss_valid (immu_miss_valid),
        .refill_en       (refill_en),
        .refill_entry    (refill_entry),
        .walk            (walk_bus.requester)
    );

    itlb_array u_tlb (
        .clk              (clk),
        .rst_n            (rst_n),
        .sflush_vma_valid (sflush_vma_valid),
        .refill_en        (refill_en),
        .refill_entry     (refill_entry),
        .lookup           (lookup_bus.array)
    );

    translate_stage u_stage (
        .clk                 (clk),
        .rst_n               (rst_n),
        .current_priv_status (current_priv_status),
        .satp_mode           (satp_mode),
        .flush_flag          (flush_flag),
        .mmu_fifo_valid      (mmu_fifo_valid),
        .vaddr               (vaddr),
        .paddr_ready         (paddr_ready),
        .satp_asid           (satp_asid),
        .mmu_fifo_ready      (mmu_fifo_ready),
        .paddr_valid         (paddr_valid),
        .paddr               (paddr),
        .paddr_error         (paddr_error),
        .lookup              (lookup_bus.stage),
        .walk                (walk_bus.stage)
    );

endmodule

// ==== tests/immu_clk_gen.sv ====
module immu_clk_gen (
    output logic clk
);

    // period of 4
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

// ==== tests/immu_tb.sv ====
module immu_tb import immu_pkg::*; ();

    localparam int WAIT_LIMIT = 100;

    logic               clk;
    logic               rst_n;
    logic [1:0]         current_priv_status;
    logic [3:0]         satp_mode;
    logic [ASID_W-1:0]  satp_asid;
    logic               flush_flag;
    logic               sflush_vma_valid;
    logic               immu_miss_valid;
    logic               immu_miss_ready;
    logic [VADDR_W-1:0] vaddr_i;
    logic               pte_valid;
    logic               pte_ready_i;
    logic [PTE_W-1:0]   pte;
    logic               pte_error;
    logic               mmu_fifo_valid;
    logic               mmu_fifo_ready;
    logic [VADDR_W-1:0] vaddr;
    logic               paddr_valid;
    logic               paddr_ready;
    logic [VADDR_W-1:0] paddr;
    logic               paddr_error;

    // output seen at the last stalled sample
    logic               stall_q;
    logic [VADDR_W-1:0] paddr_q;
    logic               error_q;

    immu_clk_gen u_clk (.clk(clk));

    immu_top u_dut (.*);

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopped at time %0t", $time);
    endtask

    task automatic value_error(input string name, input logic [VADDR_W-1:0] got,
                               input logic [VADDR_W-1:0] exp);
        stop_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    // ****************************************
    // icache back-pressure and l2 ready monitor
    // ****************************************
    always @(negedge clk) begin
        if (rst_n) begin
            assert (pte_ready_i) else value_error("pte_ready_i", pte_ready_i, 1'b1);
        end
        if (rst_n && stall_q) begin
            assert (paddr == paddr_q) else value_error("paddr", paddr, paddr_q);
            assert (paddr_error == error_q) else value_error("paddr_error", paddr_error, error_q);
        end
        if (rst_n && paddr_valid && !paddr_ready) begin
            assert (!mmu_fifo_ready) else value_error("mmu_fifo_ready", mmu_fifo_ready, 1'b0);
        end
        stall_q = rst_n & paddr_valid & ~paddr_ready;
        paddr_q = paddr;
        error_q = paddr_error;
    end

    task automatic pulse_sflush();
        @(posedge clk);
        sflush_vma_valid <= 1'b1;
        @(posedge clk);
        sflush_vma_valid <= 1'b0;
    endtask

    task automatic run_fetch(input logic [1:0] priv, input logic [3:0] smode,
                             input logic [ASID_W-1:0] asid, input logic [VADDR_W-1:0] va,
                             input logic [PPN_W-1:0] ppn, input logic g, input logic u,
                             input logic x, input logic perr, input logic exp_miss,
                             input logic [VADDR_W-1:0] exp_paddr, input logic exp_err);
        logic [PTE_W-1:0] word;
        int               cycles;
        int               delay;
        int               phase;
        logic             miss_seen;
        logic             miss_now;
        logic             fire;
        // sv39 leaf as the l2 tlb returns it
        word          = '0;
        word[127:112] = asid;
        word[111:68]  = ppn;
        word[63]      = g;
        word[62]      = u;
        word[61]      = x;
        word[57:31]   = va[38:12];
        cycles        = 0;
        delay         = 0;
        phase         = 0;
        miss_seen     = 1'b0;
        fire          = 1'b0;
        @(posedge clk);
        current_priv_status <= priv;
        satp_mode           <= smode;
        satp_asid           <= asid;
        vaddr               <= va;
        mmu_fifo_valid      <= 1'b1;
        // l2 responder runs in the same loop until the fetch is taken
        while (!fire) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) stop_run("timeout waiting for mmu_fifo_ready");
            miss_now = immu_miss_valid;
            fire     = mmu_fifo_ready;
            if (miss_now) begin
                miss_seen = 1'b1;
                assert (vaddr_i == va) else value_error("vaddr_i", vaddr_i, va);
            end
            @(posedge clk);
            immu_miss_ready <= 1'b0;
            pte_valid       <= 1'b0;
            paddr_ready     <= ($urandom % 4) != 0;
            if (phase == 0 && miss_now) begin
                immu_miss_ready <= 1'b1;
                delay = $urandom % 6;
                phase = 1;
            end else if (phase == 1) begin
                if (delay == 0) begin
                    pte       <= word;
                    pte_error <= perr;
                    pte_valid <= 1'b1;
                    phase = 2;
                end else begin
                    delay--;
                end
            end
        end
        mmu_fifo_valid <= 1'b0;
        // icache sink drains the result
        cycles = 0;
        fire   = 1'b0;
        while (!fire) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) stop_run("timeout waiting for paddr_valid");
            if (immu_miss_valid) begin
                miss_seen = 1'b1;
            end
            if (paddr_valid && paddr_ready) begin
                fire = 1'b1;
                assert (paddr_error == exp_err) else value_error("paddr_error", paddr_error, exp_err);
                if (!exp_err) begin
                    assert (paddr == exp_paddr) else value_error("paddr", paddr, exp_paddr);
                end
            end
            @(posedge clk);
            paddr_ready <= ($urandom % 4) != 0;
        end
        assert (miss_seen == exp_miss) else value_error("immu_miss_valid", miss_seen, exp_miss);
    endtask

    // ****************************************
    // main sequence
    // ****************************************
    initial begin
        int                 fd;
        int                 n;
        string              line;
        logic [3:0]         mode;
        logic [1:0]         priv;
        logic [3:0]         smode;
        logic [ASID_W-1:0]  asid;
        logic [VADDR_W-1:0] va;
        logic [PPN_W-1:0]   ppn;
        logic               g;
        logic               u;
        logic               x;
        logic               perr;
        logic               exp_miss;
        logic [VADDR_W-1:0] exp_paddr;
        logic               exp_err;
        void'($urandom(32'hfea46a34));
        rst_n               = 1'b0;
        current_priv_status = 2'd3;
        satp_mode           = 4'h0;
        satp_asid           = '0;
        flush_flag          = 1'b0;
        sflush_vma_valid    = 1'b0;
        immu_miss_ready     = 1'b0;
        pte_valid           = 1'b0;
        pte                 = '0;
        pte_error           = 1'b0;
        mmu_fifo_valid      = 1'b0;
        vaddr               = '0;
        paddr_ready         = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("tests/immu_cases.txt", "r");
        if (fd == 0) stop_run("cannot open tests/immu_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", mode, priv, smode,
                        asid, va, ppn, g, u, x, perr, exp_miss, exp_paddr, exp_err);
            if (n != 13) stop_run($sformatf("malformed case line: %s", line));
            if (mode == 4'h2) begin
                pulse_sflush();
            end else begin
                run_fetch(priv, smode, asid, va, ppn, g, u, x, perr, exp_miss, exp_paddr,
                          exp_err);
            end
        end
        $fclose(fd);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== tests/immu_cases.txt ====
# mode (0 bypass, 1 fetch, 2 sflush) priv satp_mode asid vaddr pte_ppn g u x pte_err
# then expect_miss expect_paddr expect_error; all hex, paddr checked only without error
0 3 8 0001 0000004000001234 0 0 0 0 0 0 0000004000001234 0
0 1 0 0001 ffffffc000000abc 0 0 0 0 0 0 ffffffc000000abc 0
1 1 8 0001 0000000000010123 00080 0 0 1 0 1 0000000000080123 0
1 1 8 0001 0000000000010456 00080 0 0 1 0 0 0000000000080456 0
1 1 8 0002 0000000000010789 00081 0 0 1 0 1 0000000000081789 0
1 1 8 0001 0000000000010abc 00080 0 0 1 0 0 0000000000080abc 0
1 1 8 0001 0000000000020010 00090 1 0 1 0 1 0000000000090010 0
1 1 8 0002 0000000000020020 00090 1 0 1 0 0 0000000000090020 0
1 1 8 0001 0000000000030000 000a0 0 0 0 0 1 0000000000000000 1
1 1 8 0001 0000000000031000 000a1 0 1 1 0 1 0000000000000000 1
1 0 8 0001 0000000000032000 000a2 0 0 1 0 1 0000000000000000 1
1 0 8 0001 0000000000033004 000a3 0 1 1 0 1 00000000000a3004 0
1 1 8 0001 0000000000034000 000a4 0 0 1 1 1 0000000000000000 1
1 0 8 0001 0000000000010000 00080 0 0 1 0 0 0000000000000000 1
1 1 8 0001 0000008000000000 0 0 0 0 0 0 0000000000000000 1
1 1 8 0001 8000000000000000 0 0 0 0 0 0 0000000000000000 1
1 1 8 0001 ffffffc000005678 000b0 0 0 1 0 1 00000000000b0678 0
1 1 8 0001 ffffffc000005000 000b0 0 0 1 0 0 00000000000b0000 0
2 0 0 0000 0000000000000000 0 0 0 0 0 0 0000000000000000 0
1 1 8 0001 0000000000010abc 00080 0 0 1 0 1 0000000000080abc 0
1 1 8 0002 0000000000020020 00090 1 0 1 0 1 0000000000090020 0
1 1 8 0001 0000000000010def 00080 0 0 1 0 0 0000000000080def 0

// ==== files.f ====
logic/immu_pkg.sv
logic/tlb_lookup_if.sv
logic/walk_if.sv
logic/page_walk_requester.sv
logic/itlb_array.sv
logic/translate_stage.sv
logic/immu_top.sv
tests/immu_clk_gen.sv
tests/immu_tb.sv

// ==== Bender.yml ====
package:
  name: immu

sources:
  - files:
      - logic/immu_pkg.sv
      - logic/tlb_lookup_if.sv
      - logic/walk_if.sv
      - logic/page_walk_requester.sv
      - logic/itlb_array.sv
      - logic/translate_stage.sv
      - logic/immu_top.sv
  - target: test
    files:
      - tests/immu_clk_gen.sv
      - tests/immu_tb.sv
